// File: build.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/line_assembler.sv
hdl/fetch_control.sv
hdl/fetch_queue.sv
hdl/fetch_unit.sv
test/fetch_mem_model.sv
test/tb_fetch_unit.sv

// File: hdl/fetch_control.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_control (
    input  logic                         clk,
    input  logic                         rst,

    input  fetch_pkg::redirect_t         redirect_i,

    output logic                         fill_o,
    output logic [`FETCH_ADDR_W-1:0]     fill_addr_o,
    input  logic                         fill_busy_i,
    input  fetch_pkg::line_fill_t        fill_i,

    output fetch_pkg::fetch_entry_t      enq_entry_o,
    output logic                         enq_valid_o,
    input  logic                         queue_full_i
);

    localparam int OFF_W  = $clog2(`FETCH_LINE_WORDS * `FETCH_INST_W / 8);
    localparam int TAG_W  = `FETCH_ADDR_W - OFF_W;
    localparam int WSEL_W = $clog2(`FETCH_LINE_WORDS);
    localparam logic [`FETCH_ADDR_W-1:0] PC_STEP = `FETCH_ADDR_W'(`FETCH_INST_W / 8);

    logic [`FETCH_ADDR_W-1:0] pc_q;
    logic                     buf_valid_q;
    logic [TAG_W-1:0]         buf_tag_q;
    fetch_pkg::line_t         buf_line_q;
    logic                     stale_q;

    logic                     hit;
    logic                     accept;
    logic                     fill_load;
    logic [WSEL_W-1:0]        word_sel;
    logic [TAG_W-1:0]         pc_tag;

    assign pc_tag   = pc_q[`FETCH_ADDR_W-1:OFF_W];
    assign word_sel = pc_q[OFF_W-1:OFF_W-WSEL_W];
    assign hit      = buf_valid_q && (buf_tag_q == pc_tag);
    assign accept   = hit && !queue_full_i;

    // a fill cut off by a redirect is dropped, as is one landing on the redirect cycle
    assign fill_load = fill_i.valid && !stale_q && !redirect_i.valid;

    // miss request, held back while a fill is still owed to this pc
    assign fill_o      = !hit && !redirect_i.valid && !fill_busy_i && !fill_load;
    assign fill_addr_o = pc_q;

    assign enq_valid_o = hit;

    always_comb begin
        enq_entry_o.pc   = pc_q;
        enq_entry_o.inst = buf_line_q.words[word_sel];
    end

    // pc, buffer valid and stale flag
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q        <= `FETCH_RESET_PC;
            buf_valid_q <= 1'b0;
            stale_q     <= 1'b0;
        end else begin
            if (redirect_i.valid) begin
                pc_q <= redirect_i.target;
            end else if (accept) begin
                pc_q <= pc_q + PC_STEP;
            end

            if (fill_load) begin
                buf_valid_q <= 1'b1;
            end

            // assembler busy means its line belongs to the old path
            if (redirect_i.valid) begin
                stale_q <= fill_busy_i;
            end else if (fill_i.valid) begin
                stale_q <= 1'b0;
            end
        end
    end

    // pc cannot leave the missing line except by redirect, so its tag names the fill
    always_ff @(posedge clk) begin
        if (fill_load) begin
            buf_line_q <= fill_i.line;
            buf_tag_q  <= pc_tag;
        end
    end

    a_enq_needs_line : assert property (
        @(posedge clk) disable iff (rst) enq_valid_o |-> buf_valid_q
    );

    // the assembler must pick up every request on the next cycle
    a_req_taken : assert property (
        @(posedge clk) disable iff (rst) fill_o |=> fill_busy_i
    );

endmodule

// File: hdl/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// address and instruction widths
`define FETCH_ADDR_W 32
`define FETCH_INST_W 32

// burst memory beat width
`define FETCH_BEAT_W 64

// line geometry, 256 bits
`define FETCH_LINE_WORDS 8
`define FETCH_LINE_BEATS 4

// instruction queue depth, power of two
`define FETCH_QUEUE_DEPTH 16

// first fetch address out of reset
`define FETCH_RESET_PC 32'haaaaa000

`endif

// File: hdl/fetch_pkg.sv
`include "fetch_params.svh"

package fetch_pkg;

    // one line, read as words by fetch control and written as beats by the assembler
    // beat 0 and word 0 sit in the lowest bits
    typedef union packed {
        logic [`FETCH_LINE_WORDS-1:0][`FETCH_INST_W-1:0] words;
        logic [`FETCH_LINE_BEATS-1:0][`FETCH_BEAT_W-1:0] beats;
    } line_t;

    // one queued instruction
    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0] pc;
        logic [`FETCH_INST_W-1:0] inst;
    } fetch_entry_t;

    // completed fill, valid for one cycle
    typedef struct packed {
        logic  valid;
        line_t line;
    } line_fill_t;

    // branch flush from the back end
    typedef struct packed {
        logic                     valid;
        logic [`FETCH_ADDR_W-1:0] target;
    } redirect_t;

endpackage

// File: hdl/fetch_queue.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_queue #(
    parameter int DEPTH = `FETCH_QUEUE_DEPTH
) (
    input  logic                         clk,
    input  logic                         rst,

    input  logic                         flush_i,

    input  fetch_pkg::fetch_entry_t      enq_entry_i,
    input  logic                         enq_valid_i,
    output logic                         full_o,

    output fetch_pkg::fetch_entry_t      out_entry_o,
    output logic                         out_valid_o,
    input  logic                         out_ready_i
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] DEPTH_CNT = DEPTH[PTR_W:0];

    fetch_pkg::fetch_entry_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             push;
    logic             pop;

    assign full_o      = (count_q == DEPTH_CNT);
    assign out_valid_o = (count_q != '0);
    assign out_entry_o = mem[rd_ptr_q];

    assign push = enq_valid_i && !full_o;
    assign pop  = out_valid_o && out_ready_i;

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= enq_entry_i;
        end
    end

    a_count_bound : assert property (
        @(posedge clk) disable iff (rst) count_q <= DEPTH_CNT
    );

    // head entry holds while the consumer stalls
    a_out_stable : assert property (
        @(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(out_entry_o)
    );

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_unit (
    input  logic                         clk,
    input  logic                         rst,

    input  fetch_pkg::redirect_t         redirect_i,

    output logic [`FETCH_ADDR_W-1:0]     bmem_addr_o,
    output logic                         bmem_read_o,
    input  logic [`FETCH_BEAT_W-1:0]     bmem_rdata_i,
    input  logic                         bmem_rvalid_i,

    output fetch_pkg::fetch_entry_t      out_entry_o,
    output logic                         out_valid_o,
    input  logic                         out_ready_i
);

    logic                     fill_req;
    logic [`FETCH_ADDR_W-1:0] fill_addr;
    logic                     fill_busy;
    fetch_pkg::line_fill_t    line_fill;
    fetch_pkg::fetch_entry_t  enq_entry;
    logic                     enq_valid;
    logic                     queue_full;

    line_assembler u_line_assembler (
        .clk          (clk),
        .rst          (rst),
        .fill_req_i   (fill_req),
        .fill_addr_i  (fill_addr),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_rdata_i (bmem_rdata_i),
        .bmem_rvalid_i(bmem_rvalid_i),
        .fill_o       (line_fill),
        .busy_o       (fill_busy)
    );

    fetch_control u_fetch_control (
        .clk          (clk),
        .rst          (rst),
        .redirect_i   (redirect_i),
        .fill_o       (fill_req),
        .fill_addr_o  (fill_addr),
        .fill_busy_i  (fill_busy),
        .fill_i       (line_fill),
        .enq_entry_o  (enq_entry),
        .enq_valid_o  (enq_valid),
        .queue_full_i (queue_full)
    );

    // redirect doubles as the queue flush
    fetch_queue #(
        .DEPTH        (`FETCH_QUEUE_DEPTH)
    ) u_fetch_queue (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (redirect_i.valid),
        .enq_entry_i  (enq_entry),
        .enq_valid_i  (enq_valid),
        .full_o       (queue_full),
        .out_entry_o  (out_entry_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i)
    );

endmodule

// File: hdl/line_assembler.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module line_assembler (
    input  logic                         clk,
    input  logic                         rst,

    input  logic                         fill_req_i,
    input  logic [`FETCH_ADDR_W-1:0]     fill_addr_i,

    output logic [`FETCH_ADDR_W-1:0]     bmem_addr_o,
    output logic                         bmem_read_o,
    input  logic [`FETCH_BEAT_W-1:0]     bmem_rdata_i,
    input  logic                         bmem_rvalid_i,

    output fetch_pkg::line_fill_t        fill_o,
    output logic                         busy_o
);

    localparam int OFF_W  = $clog2(`FETCH_LINE_WORDS * `FETCH_INST_W / 8);
    localparam int BCNT_W = $clog2(`FETCH_LINE_BEATS);
    localparam logic [BCNT_W-1:0] LAST_BEAT = BCNT_W'(`FETCH_LINE_BEATS - 1);

    logic                     busy_q;
    logic                     read_q;
    logic                     done_q;
    logic [BCNT_W-1:0]        beat_cnt_q;
    logic [`FETCH_ADDR_W-1:0] addr_q;
    fetch_pkg::line_t         line_q;

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q     <= 1'b0;
            read_q     <= 1'b0;
            done_q     <= 1'b0;
            beat_cnt_q <= '0;
        end else begin
            read_q <= 1'b0;
            done_q <= 1'b0;
            if (fill_req_i && !busy_q) begin
                busy_q     <= 1'b1;
                read_q     <= 1'b1;
                beat_cnt_q <= '0;
            end else if (busy_q && bmem_rvalid_i) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
                if (beat_cnt_q == LAST_BEAT) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // request address and line payload
    always_ff @(posedge clk) begin
        if (fill_req_i && !busy_q) begin
            addr_q <= {fill_addr_i[`FETCH_ADDR_W-1:OFF_W], OFF_W'(0)};
        end
        if (busy_q && bmem_rvalid_i) begin
            line_q.beats[beat_cnt_q] <= bmem_rdata_i;
        end
    end

    assign bmem_addr_o  = addr_q;
    assign bmem_read_o  = read_q;
    assign busy_o       = busy_q;
    assign fill_o.valid = done_q;
    assign fill_o.line  = line_q;

    // fetch control waits for the burst to finish before asking again
    a_no_req_while_busy : assert property (
        @(posedge clk) disable iff (rst) fill_req_i |-> !busy_q
    );

    // memory only answers an outstanding burst
    a_no_beat_while_idle : assert property (
        @(posedge clk) disable iff (rst) bmem_rvalid_i |-> busy_q
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the fetch unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_fetch_unit -f build.f -o tb_fetch_unit \
    && ./obj_dir/tb_fetch_unit | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: test/fetch_mem_model.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_mem_model #(
    parameter int PAIRS = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`FETCH_ADDR_W-1:0] addr_i,
    input  logic                     read_i,
    output logic [`FETCH_BEAT_W-1:0] rdata_o,
    output logic                     rvalid_o
);

    // cycles from the read pulse to the first beat
    localparam logic [2:0] FIRST_DELAY = 3'd3;

    logic [`FETCH_INST_W-1:0] pat_mem [2*PAIRS];
    logic                     active_q = 1'b0;
    logic [1:0]               beat_q = 2'd0;
    logic [2:0]               delay_q = 3'd0;
    logic [`FETCH_ADDR_W-1:0] base_q = '0;
    logic                     rvalid_q = 1'b0;
    logic [`FETCH_BEAT_W-1:0] rdata_q = '0;

    initial begin
        $readmemh("test/fetch_patterns.hex", pat_mem);
    end

    // listed words first, everything else follows the address
    function automatic logic [`FETCH_INST_W-1:0] word_at(input logic [`FETCH_ADDR_W-1:0] addr);
        logic [`FETCH_INST_W-1:0] val;
        val = addr ^ 32'h5a5a5a5a;
        for (int i = 0; i < PAIRS; i++) begin
            if (pat_mem[2*i] == addr) begin
                val = pat_mem[2*i+1];
            end
        end
        return val;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            active_q <= 1'b0;
            rvalid_q <= 1'b0;
            beat_q   <= 2'd0;
            delay_q  <= 3'd0;
        end else begin
            rvalid_q <= 1'b0;
            if (read_i) begin
                active_q <= 1'b1;
                base_q   <= addr_i;
                beat_q   <= 2'd0;
                delay_q  <= FIRST_DELAY;
            end else if (active_q) begin
                if (delay_q != 3'd0) begin
                    delay_q <= delay_q - 3'd1;
                end else begin
                    rvalid_q <= 1'b1;
                    rdata_q  <= {word_at(base_q + {27'd0, beat_q, 3'b100}),
                                 word_at(base_q + {27'd0, beat_q, 3'b000})};
                    beat_q   <= beat_q + 2'd1;
                    // one idle cycle after the second beat
                    delay_q  <= (beat_q == 2'd1) ? 3'd1 : 3'd0;
                    if (beat_q == 2'd3) begin
                        active_q <= 1'b0;
                    end
                end
            end
        end
    end

    assign rdata_o  = rdata_q;
    assign rvalid_o = rvalid_q;

endmodule

// File: test/fetch_patterns.hex
// columns: word address, instruction word
// unlisted addresses read as the address xor 5a5a5a5a
aaaaa000 00000513
aaaaa004 00100593
aaaaa008 00b50633
aaaaa00c 00c586b3
aaaaa010 40d60733
aaaaa014 00e6f7b3
aaaaa018 00f76833
aaaaa01c 0107c8b3
aaaaa020 00189913
aaaaa024 0018d993
aaaaa028 41f95a13
aaaaa02c 014a0ab3
aaaaa030 00aa8b13
aaaaa034 fffb0b93
aaaaa038 017b8c33
aaaaa03c 018c0cb3
aaaaa040 00052d03
aaaaa044 00452d83
aaaaa048 01a52423
aaaaa04c 01b52623
aaaab040 fe000ee3
aaaab044 00c0006f
aaaab048 00150513
aaaab04c 00258593
aaaab050 00b50633
aaaab054 00060693
aaaab058 fe0696e3
aaaab05c 00008067
// line that is cut off by the second redirect
aaaac000 0000c073
aaaac004 0040c0f3
aaaac008 0080c173
aaaac00c 00c0c1f3

// File: test/tb_fetch_unit.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module tb_fetch_unit;

    localparam int PAIRS      = 32;
    localparam int WAIT_LIMIT = 500;

    logic                     clk;
    logic                     rst;
    fetch_pkg::redirect_t     redirect;
    logic [`FETCH_ADDR_W-1:0] bmem_addr;
    logic                     bmem_read;
    logic [`FETCH_BEAT_W-1:0] bmem_rdata;
    logic                     bmem_rvalid;
    fetch_pkg::fetch_entry_t  out_entry;
    logic                     out_valid;
    logic                     out_ready;

    logic [`FETCH_INST_W-1:0] pat_mem [2*PAIRS];
    logic [`FETCH_ADDR_W-1:0] exp_pc;
    integer                   seed;
    int                       errors;
    int                       errors_at_start;
    int                       checks;
    int                       tests;
    bit                       timed_out;

    fetch_unit uut (
        .clk          (clk),
        .rst          (rst),
        .redirect_i   (redirect),
        .bmem_addr_o  (bmem_addr),
        .bmem_read_o  (bmem_read),
        .bmem_rdata_i (bmem_rdata),
        .bmem_rvalid_i(bmem_rvalid),
        .out_entry_o  (out_entry),
        .out_valid_o  (out_valid),
        .out_ready_i  (out_ready)
    );

    fetch_mem_model #(
        .PAIRS   (PAIRS)
    ) u_mem (
        .clk     (clk),
        .rst     (rst),
        .addr_i  (bmem_addr),
        .read_i  (bmem_read),
        .rdata_o (bmem_rdata),
        .rvalid_o(bmem_rvalid)
    );

    always #4 clk = ~clk;

    function automatic logic [`FETCH_INST_W-1:0] expected_inst(
        input logic [`FETCH_ADDR_W-1:0] addr
    );
        logic [`FETCH_INST_W-1:0] val;
        val = addr ^ 32'h5a5a5a5a;
        for (int i = 0; i < PAIRS; i++) begin
            if (pat_mem[2*i] == addr) begin
                val = pat_mem[2*i+1];
            end
        end
        return val;
    endfunction

    task automatic check_bit(input string name, input logic actual, input logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_addr(input string name, input logic [`FETCH_ADDR_W-1:0] actual,
                              input logic [`FETCH_ADDR_W-1:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_entry(input string name, input fetch_pkg::fetch_entry_t actual,
                               input fetch_pkg::fetch_entry_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: got pc %h inst %h, expected pc %h inst %h", name,
                     actual.pc, actual.inst, expected.pc, expected.inst);
        end
    endtask

    task automatic note_timeout(input string what);
        timed_out = 1'b1;
        errors++;
        $display("timeout: %s within %0d cycles", what, WAIT_LIMIT);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst       <= 1'b1;
        out_ready <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic send_redirect(input logic [`FETCH_ADDR_W-1:0] dest);
        @(posedge clk);
        redirect.valid  <= 1'b1;
        redirect.target <= dest;
        @(posedge clk);
        redirect <= '0;
    endtask

    // ready is raised only while waiting, so nothing drains unseen
    task automatic pop_entry(input bit random_ready, output fetch_pkg::fetch_entry_t e);
        int          waited;
        bit          got;
        logic [31:0] rnd;
        waited = 0;
        got    = 1'b0;
        e      = '0;
        while (!got && !timed_out) begin
            @(posedge clk);
            rnd = $random(seed);
            out_ready <= random_ready ? rnd[0] : 1'b1;
            @(negedge clk);
            if (out_valid && out_ready) begin
                e   = out_entry;
                got = 1'b1;
            end else begin
                waited++;
                if (waited >= WAIT_LIMIT) begin
                    note_timeout("no entry accepted");
                end
            end
        end
        @(posedge clk);
        out_ready <= 1'b0;
    endtask

    task automatic wait_for_read();
        int waited;
        waited = 0;
        while (!timed_out) begin
            @(negedge clk);
            if (bmem_read) begin
                break;
            end
            waited++;
            if (waited >= WAIT_LIMIT) begin
                note_timeout("no burst read issued");
            end
        end
    endtask

    task automatic run_sequence(input int count, input bit random_ready);
        fetch_pkg::fetch_entry_t got;
        fetch_pkg::fetch_entry_t want;
        for (int n = 0; n < count && !timed_out; n++) begin
            pop_entry(random_ready, got);
            want.pc   = exp_pc;
            want.inst = expected_inst(exp_pc);
            if (!timed_out) begin
                check_entry("out_entry_o", got, want);
            end
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin
        logic [`FETCH_ADDR_W-1:0] dest;
        clk             = 1'b0;
        rst             = 1'b1;
        redirect        = '0;
        out_ready       = 1'b0;
        seed            = 32'h9df8;
        errors          = 0;
        errors_at_start = 0;
        checks          = 0;
        tests           = 0;
        timed_out       = 1'b0;
        $readmemh("test/fetch_patterns.hex", pat_mem);

        apply_reset();
        @(negedge clk);
        check_bit("out_valid_o", out_valid, 1'b0);
        check_bit("bmem_read_o", bmem_read, 1'b0);
        exp_pc = `FETCH_RESET_PC;
        run_sequence(1, 1'b0);
        end_test("reset state");

        // rest of the first three lines
        run_sequence(23, 1'b0);
        end_test("sequential fetch");

        run_sequence(60, 1'b1);
        end_test("random back-pressure");

        // jump back into the line of the last accepted entry
        dest = ((exp_pc - 32'd4) & ~32'h1f) | 32'h08;
        send_redirect(dest);
        exp_pc = dest;
        run_sequence(10, 1'b0);
        end_test("redirect within line");

        // second redirect lands while the first target line is still in flight
        send_redirect(32'haaaac008);
        wait_for_read();
        if (!timed_out) begin
            // burst address is the start of the target line
            check_addr("bmem_addr_o", bmem_addr, 32'haaaac000);
        end
        send_redirect(32'haaaab048);
        exp_pc = 32'haaaab048;
        run_sequence(12, 1'b1);
        end_test("redirect during fill");

        run_sequence(5, 1'b0);
        apply_reset();
        @(negedge clk);
        check_bit("out_valid_o", out_valid, 1'b0);
        exp_pc = `FETCH_RESET_PC;
        run_sequence(10, 1'b0);
        end_test("reset mid-run");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
